/* rtl/tlp_stream_pkg.sv */
// ----------------------------------------------------------
// TLP stream types
// widths and vector types of the 64-bit and 128-bit TLP
// data path between the core side and the stream side
// ----------------------------------------------------------

package tlp_stream_pkg;

    // one double word
    localparam int DW_BITS  = 32;
    localparam int QW_BITS  = 2 * DW_BITS;
    localparam int OCT_BITS = 4 * DW_BITS;

    // valid flag per DW of a 128-bit word, low DWs first
    typedef logic [3:0] dw_keep_t;

    // one 128-bit stream word
    typedef logic [OCT_BITS-1:0] oct_t;

    // one 64-bit core beat
    typedef logic [QW_BITS-1:0] qw_t;

    // DWs collected in the packer, 0 to 4
    typedef logic [2:0] dw_count_t;

endpackage

/* rtl/pcie_core_pkg.sv */
// ----------------------------------------------------------
// PCIe core beat encodings
// keep values of the 64-bit AXI stream side of the core
// ----------------------------------------------------------

package pcie_core_pkg;

    // byte keep of one 64-bit beat
    typedef logic [7:0] byte_keep_t;

    // both DWs of the beat carry data
    localparam byte_keep_t KEEP_TWO_DW = 8'hff;

    // only the low DW carries data, last beat of an odd TLP
    localparam byte_keep_t KEEP_ONE_DW = 8'h0f;

    // first byte of the upper DW, enough to tell the two apart
    localparam int KEEP_HI_DW_BIT = 4;

endpackage

/* rtl/tlps128_if.sv */
// ----------------------------------------------------------
// 128-bit TLP stream
// valid/ready stream of four-DW words, valid DWs packed low
// ----------------------------------------------------------

`timescale 1ns/1ps

interface tlps128_if import tlp_stream_pkg::*; ();

    oct_t     tdata;
    dw_keep_t tkeepdw;
    logic     tlast;
    logic     tvalid;
    logic     tready;

    // producer side
    modport source (
        output tdata,
        output tkeepdw,
        output tlast,
        output tvalid,
        input  tready
    );

    // consumer side
    modport sink (
        input  tdata,
        input  tkeepdw,
        input  tlast,
        input  tvalid,
        output tready
    );

endinterface

/* rtl/tlps_src64.sv */
// ----------------------------------------------------------
// TLP stream source
// packs 64-bit receive beats of the PCIe core into 128-bit
// stream words, one word per four DWs or per TLP end
// ----------------------------------------------------------

`timescale 1ns/1ps

module tlps_src64 import tlp_stream_pkg::*, pcie_core_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    input  qw_t        rx_data,
    input  byte_keep_t rx_keep,
    input  logic       rx_last,
    input  logic       rx_valid,
    output logic       rx_ready,
    tlps128_if.source  tlps_out
);

    oct_t      word_q;
    dw_count_t dw_count;
    logic      last_q;

    logic      word_done;
    logic      rx_take;
    dw_count_t next_base;
    dw_count_t next_count;

    // ------------------------------------------------------------
    // word state
    // ------------------------------------------------------------

    // beats come in two DWs at a time, so three means four
    assign word_done = last_q || (dw_count > 3'd2);

    // a finished word must leave before the next beat lands
    assign rx_ready = !word_done || tlps_out.tready;
    assign rx_take  = rx_valid && rx_ready;

    // restart at DW 0 when the held word goes out this cycle
    assign next_base  = word_done ? 3'd0 : dw_count;
    assign next_count = next_base + (rx_keep[KEEP_HI_DW_BIT] ? 3'd2 : 3'd1);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dw_count <= '0;
            last_q   <= 1'b0;
        end else if (rx_take) begin
            dw_count <= next_count;
            last_q   <= rx_last;
        end else if (word_done && tlps_out.tready) begin
            dw_count <= '0;
            last_q   <= 1'b0;
        end
    end

    // payload at the current DW offset, base is never above 2
    always_ff @(posedge clk_pcie) begin
        if (rx_take) begin
            word_q[DW_BITS*next_base +: QW_BITS] <= rx_data;
        end
    end

    // ------------------------------------------------------------
    // stream output
    // ------------------------------------------------------------

    assign tlps_out.tdata   = word_q;
    assign tlps_out.tkeepdw = {(dw_count > 3'd3), (dw_count > 3'd2),
                               (dw_count > 3'd1), 1'b1};
    assign tlps_out.tlast   = last_q;
    assign tlps_out.tvalid  = word_done;

endmodule

/* rtl/tlps_queue.sv */
// ----------------------------------------------------------
// TLP stream queue
// ring buffer of 128-bit words between packer and splitter,
// push and pop may happen in the same cycle
// ----------------------------------------------------------

`timescale 1ns/1ps

module tlps_queue import tlp_stream_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk_pcie,
    input  logic      rst,
    tlps128_if.sink   wr,
    tlps128_if.source rd
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   fill_t;

    localparam fill_t FILL_FULL = fill_t'(QUEUE_DEPTH);

    oct_t     mem_data [QUEUE_DEPTH];
    dw_keep_t mem_keep [QUEUE_DEPTH];
    logic     mem_last [QUEUE_DEPTH];

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    fill_t fill;

    logic push;
    logic pop;

    assign wr.tready = (fill != FILL_FULL);
    assign rd.tvalid = (fill != '0);

    assign push = wr.tvalid && wr.tready;
    assign pop  = rd.tvalid && rd.tready;

    // head entry straight from the array
    assign rd.tdata   = mem_data[rd_ptr];
    assign rd.tkeepdw = mem_keep[rd_ptr];
    assign rd.tlast   = mem_last[rd_ptr];

    // ------------------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------------------

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // storage, data keep and last written as one entry
    always_ff @(posedge clk_pcie) begin
        if (push) begin
            mem_data[wr_ptr] <= wr.tdata;
            mem_keep[wr_ptr] <= wr.tkeepdw;
            mem_last[wr_ptr] <= wr.tlast;
        end
    end

endmodule

/* rtl/tlps_dst64.sv */
// ----------------------------------------------------------
// TLP stream sink
// splits 128-bit stream words into 64-bit transmit beats
// for the PCIe core, low half first
// ----------------------------------------------------------

`timescale 1ns/1ps

module tlps_dst64 import tlp_stream_pkg::*, pcie_core_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    tlps128_if.sink    tlps_in,
    output qw_t        tx_data,
    output byte_keep_t tx_keep,
    output logic       tx_last,
    output logic       tx_valid,
    input  logic       tx_ready
);

    typedef enum logic {
        SEND_LO,
        SEND_HI
    } half_state_t;

    half_state_t state;

    qw_t  hi_data_q;
    logic hi_last_q;
    logic hi_two_q;
    logic upper_dw;
    logic split;

    // word reaches into DW 2, the low beat goes now
    assign split = (state == SEND_LO) && tlps_in.tvalid && tlps_in.tkeepdw[2] && tx_ready;

    // pop once the word is fully sent
    assign tlps_in.tready = tx_ready && ((state == SEND_HI) || !tlps_in.tkeepdw[2]);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            state <= SEND_LO;
        end else if (tx_ready) begin
            state <= split ? SEND_HI : SEND_LO;
        end
    end

    // upper half of the word waiting for the next beat
    always_ff @(posedge clk_pcie) begin
        if (split) begin
            hi_data_q <= tlps_in.tdata[2*QW_BITS-1:QW_BITS];
            hi_last_q <= tlps_in.tlast;
            hi_two_q  <= tlps_in.tkeepdw[3];
        end
    end

    // ------------------------------------------------------------
    // core beat
    // ------------------------------------------------------------

    assign upper_dw = (state == SEND_HI) ? hi_two_q : tlps_in.tkeepdw[1];

    assign tx_data  = (state == SEND_HI) ? hi_data_q : tlps_in.tdata[QW_BITS-1:0];
    assign tx_keep  = upper_dw ? KEEP_TWO_DW : KEEP_ONE_DW;
    assign tx_last  = (state == SEND_HI) ? hi_last_q : (tlps_in.tlast && !tlps_in.tkeepdw[2]);
    assign tx_valid = (state == SEND_HI) || tlps_in.tvalid;

endmodule

/* rtl/pcie_tlp_loop.sv */
// ----------------------------------------------------------
// PCIe TLP loopback
// receive beats packed to 128 bits, queued, and split back
// into transmit beats in arrival order
// ----------------------------------------------------------

`timescale 1ns/1ps

module pcie_tlp_loop import tlp_stream_pkg::*, pcie_core_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk_pcie,
    input  logic       rst,

    // receive beats from the core
    input  qw_t        rx_data,
    input  byte_keep_t rx_keep,
    input  logic       rx_last,
    input  logic       rx_valid,
    output logic       rx_ready,

    // transmit beats to the core
    output qw_t        tx_data,
    output byte_keep_t tx_keep,
    output logic       tx_last,
    output logic       tx_valid,
    input  logic       tx_ready
);

    tlps128_if tlps_rx ();
    tlps128_if tlps_tx ();

    // ------------------------------------------------------------
    // receive packer
    // ------------------------------------------------------------

    tlps_src64 i_tlps_src64 (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_keep  (rx_keep),
        .rx_last  (rx_last),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tlps_out (tlps_rx.source)
    );

    // ------------------------------------------------------------
    // word queue
    // ------------------------------------------------------------

    tlps_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_tlps_queue (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .wr       (tlps_rx.sink),
        .rd       (tlps_tx.source)
    );

    // ------------------------------------------------------------
    // transmit splitter
    // ------------------------------------------------------------

    tlps_dst64 i_tlps_dst64 (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .tlps_in  (tlps_tx.sink),
        .tx_data  (tx_data),
        .tx_keep  (tx_keep),
        .tx_last  (tx_last),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

endmodule

/* testbench/tb_loop_props.sv */
// ----------------------------------------------------------
// loopback handshake properties
// a stalled beat must hold valid and payload on rx and tx
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_loop_props import tlp_stream_pkg::*, pcie_core_pkg::*; (
    input logic       clk_pcie,
    input logic       rst,
    input qw_t        rx_data,
    input byte_keep_t rx_keep,
    input logic       rx_last,
    input logic       rx_valid,
    input logic       rx_ready,
    input qw_t        tx_data,
    input byte_keep_t tx_keep,
    input logic       tx_last,
    input logic       tx_valid,
    input logic       tx_ready
);

    rx_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        (rx_valid && !rx_ready) |=>
        (rx_valid && $stable(rx_data) && $stable(rx_keep) && $stable(rx_last)))
        else $error("rx beat changed while stalled");

    tx_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        (tx_valid && !tx_ready) |=>
        (tx_valid && $stable(tx_data) && $stable(tx_keep) && $stable(tx_last)))
        else $error("tx beat changed while stalled");

endmodule

/* testbench/tb_checker.sv */
// ----------------------------------------------------------
// loopback checker
// compares every transferred tx beat with the expected list
// and checks reset state and input back-pressure
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_checker import tlp_stream_pkg::*, pcie_core_pkg::*; #(
    parameter int MAX_BEATS = 32,
    parameter int PASSES    = 3
) (
    input  logic       clk_pcie,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic       rx_ready,
    input  qw_t        tx_data,
    input  byte_keep_t tx_keep,
    input  logic       tx_last,
    input  logic       tx_valid,
    input  logic       tx_ready,
    input  logic       bp_phase,
    input  logic       end_of_test,
    output int         tx_count,
    output int         errors
);

    // data, keep, last, gap per entry, same layout as the stimulus
    logic [83:0] expect_mem [MAX_BEATS];
    logic [83:0] exp_beat;
    int          num_beats;
    int          stalls;
    logic        after_rst;
    logic        ended;

    initial begin
        for (int i = 0; i < MAX_BEATS; i++) begin
            expect_mem[i] = '0;
        end
        $readmemh("testbench/tlp_input.txt", expect_mem);
        num_beats = 0;
        while (num_beats < MAX_BEATS && expect_mem[num_beats][19:12] != 8'h00) begin
            num_beats++;
        end
    end

    // first pass runs with gaps, the rest under random tx_ready
    function automatic string test_name(input int index);
        return (index < num_beats) ? "tlp_lengths" : "back_pressure";
    endfunction

    task automatic report_mismatch(input string name, input int index, input string field,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("CHECK FAILED %s beat %0d %s expected %h actual %h",
                 name, index, field, expected, actual);
        errors = errors + 1;
    endtask

    // ------------------------------------------------------------
    // per-cycle monitor
    // ------------------------------------------------------------

    always @(posedge clk_pcie) begin
        if (rst) begin
            tx_count  = 0;
            stalls    = 0;
            errors    = 0;
            after_rst = 1'b1;
            ended     = 1'b0;
        end else begin
            if (after_rst) begin
                after_rst = 1'b0;
                if (tx_valid !== 1'b0) begin
                    report_mismatch("reset_state", 0, "tx_valid", 64'd0, 64'(tx_valid));
                end
                if (rx_ready !== 1'b1) begin
                    report_mismatch("reset_state", 0, "rx_ready", 64'd1, 64'(rx_ready));
                end
            end
            if (bp_phase && rx_valid && !rx_ready) begin
                stalls = stalls + 1;
            end
            if (tx_valid && tx_ready) begin
                if (tx_count >= PASSES * num_beats) begin
                    $display("tx beat %0d arrived after the whole expected list", tx_count);
                    errors = errors + 1;
                end else begin
                    exp_beat = expect_mem[tx_count % num_beats];
                    if (tx_data !== exp_beat[83:20]) begin
                        report_mismatch(test_name(tx_count), tx_count, "data",
                                        exp_beat[83:20], tx_data);
                    end
                    if (tx_keep !== exp_beat[19:12]) begin
                        report_mismatch(test_name(tx_count), tx_count, "keep",
                                        64'(exp_beat[19:12]), 64'(tx_keep));
                    end
                    if (tx_last !== exp_beat[8]) begin
                        report_mismatch(test_name(tx_count), tx_count, "last",
                                        64'(exp_beat[8]), 64'(tx_last));
                    end
                end
                tx_count = tx_count + 1;
            end
            if (end_of_test && !ended) begin
                ended = 1'b1;
                if (tx_count != PASSES * num_beats) begin
                    report_mismatch("beat_count", tx_count, "total",
                                    64'(PASSES * num_beats), 64'(tx_count));
                end
                if (stalls == 0) begin
                    $display("rx_ready never fell under back-pressure on the tx side");
                    errors = errors + 1;
                end
            end
        end
    end

endmodule

/* testbench/tb_top.sv */
// ----------------------------------------------------------
// loopback testbench
// replays the beat list on rx, once with gaps and twice under
// random tx_ready, and prints the closing report
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_top import tlp_stream_pkg::*, pcie_core_pkg::*; ();

    localparam int MAX_BEATS  = 32;
    localparam int PASSES     = 3;
    localparam int WAIT_LIMIT = 2000;

    logic       clk_pcie;
    logic       rst;
    qw_t        rx_data;
    byte_keep_t rx_keep;
    logic       rx_last;
    logic       rx_valid;
    logic       rx_ready;
    qw_t        tx_data;
    byte_keep_t tx_keep;
    logic       tx_last;
    logic       tx_valid;
    logic       tx_ready;

    logic        bp_phase;
    logic        end_of_test;
    logic [31:0] lfsr;
    logic [83:0] beat_mem [MAX_BEATS];
    int          num_beats;
    int          tb_errors;
    int          check_errors;
    int          tx_count;

    pcie_tlp_loop #(
        .QUEUE_DEPTH (4)
    ) i_dut (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_keep  (rx_keep),
        .rx_last  (rx_last),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_keep  (tx_keep),
        .tx_last  (tx_last),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    tb_checker #(
        .MAX_BEATS (MAX_BEATS),
        .PASSES    (PASSES)
    ) i_checker (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .tx_data     (tx_data),
        .tx_keep     (tx_keep),
        .tx_last     (tx_last),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .bp_phase    (bp_phase),
        .end_of_test (end_of_test),
        .tx_count    (tx_count),
        .errors      (check_errors)
    );

    bind pcie_tlp_loop tb_loop_props i_props (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_keep  (rx_keep),
        .rx_last  (rx_last),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_keep  (tx_keep),
        .tx_last  (tx_last),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'ha300_0000;
        end
        return state >> 1;
    endfunction

    initial begin
        clk_pcie = 1'b0;
        forever #2 clk_pcie = ~clk_pcie;
    end

    // one LFSR step per back-pressure cycle, tx_ready high otherwise
    initial begin
        lfsr     = 32'hc6c6_cb2e;
        tx_ready = 1'b1;
        forever begin
            @(posedge clk_pcie);
            if (bp_phase) begin
                #1;
                lfsr     = lfsr_step(lfsr);
                tx_ready = lfsr[0];
            end else begin
                #1;
                tx_ready = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // rx stimulus
    // ------------------------------------------------------------

    // entered and left 1 ns after a rising edge
    task automatic send_beat(input logic [83:0] beat, input logic use_gap);
        int gap;
        int waited;
        gap    = use_gap ? int'(beat[7:0]) : 0;
        waited = 0;
        for (int g = 0; g < gap; g++) begin
            @(posedge clk_pcie);
            #1;
        end
        rx_data  = beat[83:20];
        rx_keep  = beat[19:12];
        rx_last  = beat[8];
        rx_valid = 1'b1;
        // rx_ready comes from registers only, settled 1 ns after the edge
        while (!rx_ready && waited < WAIT_LIMIT) begin
            @(posedge clk_pcie);
            #1;
            waited++;
        end
        if (!rx_ready) begin
            $display("timeout: rx beat not accepted within %0d cycles", WAIT_LIMIT);
            tb_errors++;
        end else begin
            @(posedge clk_pcie);
            #1;
        end
        rx_valid = 1'b0;
    endtask

    task automatic send_pass(input logic use_gap);
        for (int i = 0; i < num_beats; i++) begin
            if (tb_errors == 0) begin
                send_beat(beat_mem[i], use_gap);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (tx_count < PASSES * num_beats && waited < WAIT_LIMIT) begin
            @(posedge clk_pcie);
            #1;
            waited++;
        end
        if (tx_count < PASSES * num_beats) begin
            $display("timeout: tx side stopped after %0d beats", tx_count);
            tb_errors++;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        rst         = 1'b1;
        rx_data     = '0;
        rx_keep     = '0;
        rx_last     = 1'b0;
        rx_valid    = 1'b0;
        bp_phase    = 1'b0;
        end_of_test = 1'b0;
        tb_errors   = 0;
        for (int i = 0; i < MAX_BEATS; i++) begin
            beat_mem[i] = '0;
        end
        $readmemh("testbench/tlp_input.txt", beat_mem);
        num_beats = 0;
        while (num_beats < MAX_BEATS && beat_mem[num_beats][19:12] != 8'h00) begin
            num_beats++;
        end
        if (num_beats == 0) begin
            $display("the input file holds no beats");
            tb_errors++;
        end
        repeat (5) @(posedge clk_pcie);
        #1;
        rst = 1'b0;
        send_pass(1'b1);
        bp_phase = 1'b1;
        send_pass(1'b0);
        send_pass(1'b0);
        if (tb_errors == 0) begin
            wait_drain();
        end
        @(posedge clk_pcie);
        #1;
        end_of_test = 1'b1;
        repeat (2) @(posedge clk_pcie);
        #1;
        $display("closing report: %0d checker errors, %0d testbench errors, %0d of %0d tx beats",
                 check_errors, tb_errors, tx_count, PASSES * num_beats);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tlp_input.txt */
// columns: beat data (16 hex digits), byte keep (2), last (1), idle cycles before it (2)
// each rx beat comes back on tx unchanged and in the same order
deadbeef110000010f103
2200000222000001ff102
3300000233000001ff001
a5a5a5a5330000030f101
4400000244000001ff002
4400000444000003ff100
5500000255000001ff003
5500000455000003ff001
01234567550000050f100
6600000266000001ff002
6600000466000003ff000
6600000666000005ff000
6600000866000007ff001
89abcdef660000090f100
7700000277000001ff000
7700000477000003ff000
7700000677000005ff100
8800000288000001ff000
8800000488000003ff000
8800000688000005ff000
fedcba98880000070f100
cafef00d990000010f100

/* tb.f */
rtl/tlp_stream_pkg.sv
rtl/pcie_core_pkg.sv
rtl/tlps128_if.sv
rtl/tlps_src64.sv
rtl/tlps_queue.sv
rtl/tlps_dst64.sv
rtl/pcie_tlp_loop.sv
testbench/tb_loop_props.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the TLP loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f tb.f \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_top)"
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
